/* project.f */
source/link_cfg_pkg.sv
source/phy_lane_pkg.sv
source/st_beat_pack.sv
source/ll_online_seq.sv
source/ll_credit_tx.sv
source/phy_lane_concat.sv
source/axi_st_master_top.sv
sim/axi_st_master_properties.sv
sim/axi_st_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the link transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module axi_st_master_tb -Mdir obj_dir -f project.f

./obj_dir/Vaxi_st_master_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

/* sim/axi_st_master_tb.sv */
// Testbench for the link transmit top, with LFSR beats, a lane reference and a scoreboard
module axi_st_master_tb
  import link_cfg_pkg::*, phy_lane_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CREDIT_W     = 8;
  localparam int MARKER_W     = 2;
  localparam int RESET_CYCLES = 16;
  localparam int DX           = 5;
  localparam int DY           = 9;
  localparam int DZ           = 3;
  localparam int LINK_DLY     = (DX > DY) ? DX : DY;
  localparam int NUM_BEATS    = 200;
  // Four on the initial credit, three on returned credit
  localparam int CREDIT_BEATS = 7;
  localparam int TIMEOUT_CYCLES = DX + DY + DZ + 4 * (NUM_BEATS + CREDIT_BEATS) + 200;
  localparam logic [CREDIT_W-1:0] BIG_CREDIT = 8'd250;

  logic                clk_wr = 1'b0;
  logic                rst_n;
  logic                tx_online;
  logic                rx_online;
  logic [CREDIT_W-1:0] init_st_credit;
  lane_t               tx_phy0;
  lane_t               tx_phy1;
  lane_t               rx_phy0;
  logic [KEEP_W-1:0]   user_tkeep;
  logic [DATA_W-1:0]   user_tdata;
  logic                user_tlast;
  logic                user_tvalid;
  logic                user_tready;
  logic [DEBUG_W-1:0]  tx_st_debug_status;
  logic [MARKER_W-1:0] tx_mrk_userbit;
  logic                tx_stb_userbit;
  logic [DELAY_W-1:0]  delay_x_value;
  logic [DELAY_W-1:0]  delay_y_value;
  logic [DELAY_W-1:0]  delay_z_value;

  // Scoreboard, lanes as {lane1, lane0}, with the cycle each push is due
  logic [2*LANE_W-1:0] exp_q[$];
  int                  cyc_q[$];

  logic [31:0] lfsr_state = 32'he16c;
  int cycle_cnt          = 0;
  int errors             = 0;
  int checks             = 0;
  int tests_run          = 0;
  int total_accepts      = 0;
  int pushes_seen        = 0;
  int load_credit        = 0;
  int accepts_since_load = 0;
  int returns_since_load = 0;

  axi_st_master_top #(
    .CREDIT_W (CREDIT_W),
    .MARKER_W (MARKER_W)
  ) UUT (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .init_st_credit     (init_st_credit),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .tx_phy1            (tx_phy1),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .tx_st_debug_status (tx_st_debug_status),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .tx_stb_userbit     (tx_stb_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value)
  );

  // 8 ns clock
  always #4 clk_wr = ~clk_wr;

  //////////////////////////////////////////////////
  // Reference model

  // Lane layout rule applied to one beat
  function automatic logic [2*LANE_W-1:0] expected_lanes(input logic                push,
                                                         input logic [KEEP_W-1:0]   keep,
                                                         input logic [DATA_W-1:0]   data,
                                                         input logic                last,
                                                         input logic                stb,
                                                         input logic [MARKER_W-1:0] mrk);
    logic [WORD_W-1:0] word;
    lane_t             lane0;
    lane_t             lane1;
    // Keep on top, data below, last in bit 0
    word  = push ? {keep, data, last} : '0;
    // Marker, strobe, low 37 word bits, push
    lane0 = {mrk[0], stb, word[36:0], push};
    // Marker, three spare zeros, high 36 word bits
    lane1 = {mrk[MARKER_W-1], 3'b000, word[72:37]};
    return {lane1, lane0};
  endfunction

  function automatic logic [DEBUG_W-1:0] expected_debug(input int                  pushes,
                                                        input logic                rx_up,
                                                        input logic                tx_up,
                                                        input logic [CREDIT_W-1:0] credit);
    return {pushes[15:0], 6'b000000, rx_up, tx_up, credit};
  endfunction

  // Initial credit, minus spends, plus returns
  function automatic logic [CREDIT_W-1:0] model_credit();
    return CREDIT_W'(load_credit + returns_since_load - accepts_since_load);
  endfunction

  //////////////////////////////////////////////////
  // Random source
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[62:0], lfsr_state[0]};
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  task automatic check_lane(input string name, input lane_t actual, input lane_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at cycle %0d",
               name, actual, expected, cycle_cnt);
    end
  endtask

  task automatic check_debug(input string name, input logic [DEBUG_W-1:0] actual,
                             input logic [DEBUG_W-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at cycle %0d",
               name, actual, expected, cycle_cnt);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at cycle %0d",
               name, actual, expected, cycle_cnt);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers, all entered 1 ns after a rising edge

  task automatic step_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  // New beat, or a one cycle gap
  task automatic next_beat(input bit gaps);
    logic [63:0] bits;
    take_bits(2, bits);
    if (gaps && bits[1:0] == 2'b00) begin
      user_tvalid = 1'b0;
    end else begin
      take_bits(DATA_W, bits);
      user_tdata  = bits;
      take_bits(KEEP_W, bits);
      user_tkeep  = bits[KEEP_W-1:0];
      take_bits(1, bits);
      user_tlast  = bits[0];
      user_tvalid = 1'b1;
    end
  endtask

  // Offer beats until max_beats taken or max_cycles spent
  // A beat not taken stays on the bus unchanged
  task automatic run_stream(input int max_beats, input int max_cycles, input bit gaps,
                            output int accepted, output int first_cyc);
    int cyc;
    bit took;
    accepted  = 0;
    first_cyc = -1;
    cyc       = 0;
    while (accepted < max_beats && cyc < max_cycles) begin
      if (!user_tvalid) begin
        next_beat(gaps);
      end
      @(negedge clk_wr);
      took = user_tvalid && user_tready;
      step_cycle();
      cyc++;
      if (took) begin
        accepted++;
        if (first_cyc < 0) begin
          first_cyc = cyc;
        end
        user_tvalid = 1'b0;
      end
    end
  endtask

  // One cycle credit pulse on the receive lane
  task automatic return_credit();
    rx_phy0[CRED_BIT] = 1'b1;
    step_cycle();
    rx_phy0[CRED_BIT] = 1'b0;
    returns_since_load++;
  endtask

  // Wait for every accepted word to leave on the lanes
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_wr);
    end
    #1;
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    $display("Test %0d %s: %s", tests_run, name, (errors == errors_before) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  // Outputs are stable at the falling edge
  always @(negedge clk_wr) begin
    logic [2*LANE_W-1:0] exp_lanes;
    int                  exp_cyc;
    if (rst_n) begin
      if (tx_phy0[PUSH_BIT]) begin
        pushes_seen++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Push on tx_phy0 at cycle %0d without an accepted beat", cycle_cnt);
        end else begin
          exp_lanes = exp_q.pop_front();
          exp_cyc   = cyc_q.pop_front();
          check_lane("tx_phy0", tx_phy0, exp_lanes[LANE_W-1:0]);
          check_lane("tx_phy1", tx_phy1, exp_lanes[2*LANE_W-1:LANE_W]);
          if (cycle_cnt != exp_cyc) begin
            errors++;
            $display("Push arrived at cycle %0d, but was due at cycle %0d", cycle_cnt, exp_cyc);
          end
        end
      end
      // Accept on the coming edge, push due two edges on
      if (user_tvalid && user_tready) begin
        exp_q.push_back(expected_lanes(1'b1, user_tkeep, user_tdata, user_tlast,
                                       tx_stb_userbit, tx_mrk_userbit));
        cyc_q.push_back(cycle_cnt + 2);
        total_accepts++;
        accepts_since_load++;
      end
    end
  end

  // Watchdog
  always @(posedge clk_wr) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  initial begin
    int                  start;
    int                  n;
    int                  first;
    logic                tx_up;
    logic                rx_up;
    logic                link;
    logic [2*LANE_W-1:0] lanes;
    logic [CREDIT_W-1:0] credit_now;

    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_st_credit = BIG_CREDIT;
    rx_phy0        = '0;
    user_tkeep     = '0;
    user_tdata     = '0;
    user_tlast     = 1'b0;
    user_tvalid    = 1'b0;
    tx_mrk_userbit = 2'b10;
    tx_stb_userbit = 1'b1;
    delay_x_value  = DELAY_W'(DX);
    delay_y_value  = DELAY_W'(DY);
    delay_z_value  = DELAY_W'(DZ);

    repeat (RESET_CYCLES) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Reset and offline
    start = errors;
    repeat (3) step_cycle();
    @(negedge clk_wr);
    check_bit("user_tready", user_tready, 1'b0);
    check_lane("tx_phy0", tx_phy0, '0);
    check_lane("tx_phy1", tx_phy1, '0);
    check_debug("tx_st_debug_status", tx_st_debug_status, '0);
    step_cycle();
    end_test("reset and offline", start);

    // Online delays, user bits and first ready
    // Lane user bits trail the sequencer by the lane register
    start       = errors;
    load_credit = BIG_CREDIT;
    tx_online   = 1'b1;
    rx_online   = 1'b1;
    for (int k = 1; k <= LINK_DLY + 4; k++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      tx_up = (k >= DX + 1);
      rx_up = (k >= DY + 1);
      link  = (k >= LINK_DLY + 2);
      lanes = expected_lanes(1'b0, '0, '0, 1'b0, (k >= DX + DZ + 2) & tx_stb_userbit,
                             (k >= DX + 2) ? tx_mrk_userbit : '0);
      check_lane("tx_phy0", tx_phy0, lanes[LANE_W-1:0]);
      check_lane("tx_phy1", tx_phy1, lanes[2*LANE_W-1:LANE_W]);
      check_debug("tx_st_debug_status", tx_st_debug_status,
                  expected_debug(0, rx_up, tx_up, link ? BIG_CREDIT : 8'h00));
      check_bit("user_tready", user_tready, link);
    end
    step_cycle();
    end_test("online delays and user bits", start);

    // Random beats with gaps
    start = errors;
    run_stream(NUM_BEATS, 4 * NUM_BEATS, 1'b1, n, first);
    if (n != NUM_BEATS) begin
      errors++;
      $display("Only %0d of %0d random beats were accepted", n, NUM_BEATS);
    end
    drain();
    end_test("data integrity", start);

    // Link drop and reload with a small credit
    start      = errors;
    credit_now = model_credit();
    rx_online  = 1'b0;
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_bit("user_tready", user_tready, 1'b0);
    check_debug("tx_st_debug_status", tx_st_debug_status,
                expected_debug(total_accepts, 1'b0, 1'b1, credit_now));
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_debug("tx_st_debug_status", tx_st_debug_status,
                expected_debug(total_accepts, 1'b0, 1'b1, 8'h00));
    step_cycle();
    init_st_credit     = 8'd4;
    rx_online          = 1'b1;
    load_credit        = 4;
    accepts_since_load = 0;
    returns_since_load = 0;
    for (int k = 1; k <= DY + 3; k++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      rx_up = (k >= DY + 1);
      link  = (k >= DY + 2);
      check_debug("tx_st_debug_status", tx_st_debug_status,
                  expected_debug(total_accepts, rx_up, 1'b1, link ? 8'd4 : 8'h00));
      check_bit("user_tready", user_tready, link);
    end
    step_cycle();
    end_test("link drop and reload", start);

    // Back-pressure with four credits, then one beat per return
    start = errors;
    run_stream(100, 20, 1'b0, n, first);
    if (n != 4) begin
      errors++;
      $display("%0d beats accepted on an initial credit of 4", n);
    end
    @(negedge clk_wr);
    check_bit("user_tready", user_tready, 1'b0);
    step_cycle();
    for (int p = 0; p < CREDIT_BEATS - 4; p++) begin
      return_credit();
      run_stream(100, 8, 1'b0, n, first);
      if (n != 1 || first != 2) begin
        errors++;
        $display("Credit return %0d let %0d beats through, first after %0d edges",
                 p, n, first);
      end
    end
    user_tvalid = 1'b0;
    drain();
    end_test("credit back-pressure", start);

    // Status word against the model, two unspent returns
    start = errors;
    return_credit();
    return_credit();
    repeat (3) step_cycle();
    @(negedge clk_wr);
    check_debug("tx_st_debug_status", tx_st_debug_status,
                expected_debug(total_accepts, 1'b1, 1'b1, model_credit()));
    if (pushes_seen != total_accepts) begin
      errors++;
      $display("%0d pushes seen on the lanes for %0d accepted beats", pushes_seen, total_accepts);
    end
    step_cycle();
    end_test("debug status", start);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d accepted beats never reached the lanes", exp_q.size());
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim/axi_st_master_properties.sv */
// Concurrent checks on the link transmit top level handshake and lane ports
module axi_st_master_properties
  import phy_lane_pkg::*;
(
  input logic  clk_wr,
  input logic  rst_n,
  input logic  tx_online,
  input logic  rx_online,
  input logic  user_tvalid,
  input logic  user_tready,
  input lane_t tx_phy0,
  input lane_t tx_phy1
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // Handshake
  // Delayed levels follow the raw ones by one edge at the earliest
  ready_needs_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_tready |-> ($past(tx_online) && $past(rx_online)))
    else $error("user_tready high while a link side is offline");

  //////////////////////////////////////////////////
  // Accept to lane push two edges later
  push_follows_accept: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (user_tvalid && user_tready) |-> ##2 tx_phy0[PUSH_BIT])
    else $error("accepted beat did not reach the lane push bit two edges later");

  push_has_accept: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy0[PUSH_BIT] |-> $past(user_tvalid && user_tready, 2))
    else $error("lane push bit without an accepted beat two edges earlier");

  //////////////////////////////////////////////////
  // Lane contents
  // Idle lanes hold user bits only
  idle_lane_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_phy0[PUSH_BIT] |-> (tx_phy0[LO_LSB +: LO_BITS] == '0) &&
                           (tx_phy1[HI_LSB +: HI_BITS] == '0))
    else $error("idle lane carries a nonzero data field");

endmodule

bind axi_st_master_top axi_st_master_properties u_properties (
  .clk_wr      (clk_wr),
  .rst_n       (rst_n),
  .tx_online   (tx_online),
  .rx_online   (rx_online),
  .user_tvalid (user_tvalid),
  .user_tready (user_tready),
  .tx_phy0     (tx_phy0),
  .tx_phy1     (tx_phy1)
);

/* source/axi_st_master_top.sv */
// Streaming link transmit top joining packer, credit stage, lane concat and sequencer
module axi_st_master_top
  import link_cfg_pkg::*, phy_lane_pkg::*;
#(
  parameter int CREDIT_W = 8,
  parameter int MARKER_W = 2
) (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,
  input  logic [CREDIT_W-1:0] init_st_credit,

  // PHY lanes
  output lane_t               tx_phy0,
  input  lane_t               rx_phy0,
  output lane_t               tx_phy1,

  // User stream
  input  logic [KEEP_W-1:0]   user_tkeep,
  input  logic [DATA_W-1:0]   user_tdata,
  input  logic                user_tlast,
  input  logic                user_tvalid,
  output logic                user_tready,

  // Status
  output logic [DEBUG_W-1:0]  tx_st_debug_status,

  // User bits and delays
  input  logic [MARKER_W-1:0] tx_mrk_userbit,
  input  logic                tx_stb_userbit,
  input  logic [DELAY_W-1:0]  delay_x_value,
  input  logic [DELAY_W-1:0]  delay_y_value,
  input  logic [DELAY_W-1:0]  delay_z_value
);

  //////////////////////////////////////////////////
  // Internal wires
  st_word_t            st_word;
  st_word_t            tx_word;
  logic                tx_push;
  logic                rx_credit;
  logic                tx_online_dly;
  logic                rx_online_dly;
  logic [MARKER_W-1:0] auto_mrk_userbit;
  logic                auto_stb_userbit;

  //////////////////////////////////////////////////
  // Online sequencer
  ll_online_seq #(.MARKER_W(MARKER_W)) u_online_seq (
    .clk_wr           (clk_wr),
    .rst_n            (rst_n),
    .tx_online        (tx_online),
    .rx_online        (rx_online),
    .delay_x_value    (delay_x_value),
    .delay_y_value    (delay_y_value),
    .delay_z_value    (delay_z_value),
    .tx_mrk_userbit   (tx_mrk_userbit),
    .tx_stb_userbit   (tx_stb_userbit),
    .tx_online_dly    (tx_online_dly),
    .rx_online_dly    (rx_online_dly),
    .auto_mrk_userbit (auto_mrk_userbit),
    .auto_stb_userbit (auto_stb_userbit)
  );

  //////////////////////////////////////////////////
  // User beat packing
  st_beat_pack u_beat_pack (
    .user_tkeep (user_tkeep),
    .user_tdata (user_tdata),
    .user_tlast (user_tlast),
    .st_word    (st_word)
  );

  //////////////////////////////////////////////////
  // Credit transmit
  ll_credit_tx #(.CREDIT_W(CREDIT_W)) u_credit_tx (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online_dly      (tx_online_dly),
    .rx_online_dly      (rx_online_dly),
    .init_st_credit     (init_st_credit),
    .st_word            (st_word),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_credit          (rx_credit),
    .tx_word            (tx_word),
    .tx_push            (tx_push),
    .tx_st_debug_status (tx_st_debug_status)
  );

  //////////////////////////////////////////////////
  // PHY lanes
  phy_lane_concat #(.MARKER_W(MARKER_W)) u_lane_concat (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_word     (tx_word),
    .tx_push     (tx_push),
    .stb_userbit (auto_stb_userbit),
    .mrk_userbit (auto_mrk_userbit),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .rx_phy0     (rx_phy0),
    .rx_credit   (rx_credit)
  );

endmodule

/* source/phy_lane_concat.sv */
// PHY lane concat that registers link words onto two lanes and samples returned credit
module phy_lane_concat
  import link_cfg_pkg::*, phy_lane_pkg::*;
#(
  parameter int MARKER_W = 2
) (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Word from credit stage
  input  st_word_t            tx_word,
  input  logic                tx_push,

  // Sequenced user bits
  input  logic                stb_userbit,
  input  logic [MARKER_W-1:0] mrk_userbit,

  // PHY lanes
  output lane_t               tx_phy0,
  output lane_t               tx_phy1,
  input  lane_t               rx_phy0,

  // Credit pulse back to credit stage
  output logic                rx_credit
);

  lane_t    lane0_d;
  lane_t    lane1_d;
  st_word_t word_q;

  //////////////////////////////////////////////////
  // Lane assembly
  always_comb begin
    // Idle lanes carry no data
    word_q  = tx_push ? tx_word : '0;
    lane0_d = '0;
    lane1_d = '0;

    lane0_d[PUSH_BIT]          = tx_push;
    lane0_d[LO_LSB +: LO_BITS] = word_q[LO_BITS-1:0];
    lane0_d[STB_BIT]           = stb_userbit;
    lane0_d[MRK_BIT]           = mrk_userbit[0];

    // Upper word slice, bits 36 to 38 left at zero
    lane1_d[HI_LSB +: HI_BITS] = word_q[WORD_W-1:LO_BITS];
    lane1_d[MRK_BIT]           = mrk_userbit[MARKER_W-1];
  end

  //////////////////////////////////////////////////
  // Lane registers and credit sample
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0   <= '0;
      tx_phy1   <= '0;
      rx_credit <= 1'b0;
    end else begin
      tx_phy0   <= lane0_d;
      tx_phy1   <= lane1_d;
      // One edge of receive latency
      rx_credit <= rx_phy0[CRED_BIT];
    end
  end

endmodule

/* source/ll_credit_tx.sv */
// Credit transmit stage with ready, output word register, push pulse and status
module ll_credit_tx
  import link_cfg_pkg::*;
#(
  parameter int CREDIT_W = 8
) (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Delayed online levels
  input  logic                tx_online_dly,
  input  logic                rx_online_dly,

  // Credit loaded at link up
  input  logic [CREDIT_W-1:0] init_st_credit,

  // Packed beat and user handshake
  input  st_word_t            st_word,
  input  logic                user_tvalid,
  output logic                user_tready,

  // Returned credit pulse
  input  logic                rx_credit,

  // Word toward the lanes
  output st_word_t            tx_word,
  output logic                tx_push,

  // Status
  output logic [DEBUG_W-1:0]  tx_st_debug_status
);

  localparam int PUSH_CNT_W = 16;

  logic                  link_up;
  logic                  link_q;
  logic                  accept;
  logic [CREDIT_W-1:0]   credit_cnt;
  logic [PUSH_CNT_W-1:0] push_cnt;

  //////////////////////////////////////////////////
  // Handshake
  assign link_up     = tx_online_dly & rx_online_dly;
  // Ready needs link up and a spare far end buffer
  assign user_tready = link_up & (credit_cnt != '0);
  assign accept      = user_tvalid & user_tready;

  //////////////////////////////////////////////////
  // Credit counter
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      link_q     <= 1'b0;
      credit_cnt <= '0;
    end else if (!link_up) begin
      // Link dropped, forget all credit
      link_q     <= 1'b0;
      credit_cnt <= '0;
    end else if (!link_q) begin
      // First edge with link up
      link_q     <= 1'b1;
      credit_cnt <= init_st_credit;
    end else begin
      case ({accept, rx_credit})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: begin
          // Saturate at counter max
          if (credit_cnt != {CREDIT_W{1'b1}}) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        // Spend and return cancel out
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output register
  // One entry, refilled every accept
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      tx_word <= st_word;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_push  <= 1'b0;
      push_cnt <= '0;
    end else begin
      // Single cycle push per accepted beat
      tx_push <= accept;
      if (accept) begin
        push_cnt <= push_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Debug status
  // push count [31:16], rx online [9], tx online [8], credit [7:0]
  assign tx_st_debug_status = DEBUG_W'({push_cnt, 6'b0, rx_online_dly, tx_online_dly,
                                        8'(credit_cnt)});

endmodule

/* source/ll_online_seq.sv */
// Online sequencer that delays link online levels and gates the auto user bits
module ll_online_seq
  import link_cfg_pkg::*;
#(
  parameter int MARKER_W = 2
) (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Raw online levels
  input  logic                tx_online,
  input  logic                rx_online,

  // Programmable delays in cycles
  input  logic [DELAY_W-1:0]  delay_x_value,
  input  logic [DELAY_W-1:0]  delay_y_value,
  input  logic [DELAY_W-1:0]  delay_z_value,

  // User bit sources
  input  logic [MARKER_W-1:0] tx_mrk_userbit,
  input  logic                tx_stb_userbit,

  // Delayed levels
  output logic                tx_online_dly,
  output logic                rx_online_dly,

  // Gated user bits toward the lanes
  output logic [MARKER_W-1:0] auto_mrk_userbit,
  output logic                auto_stb_userbit
);

  logic [DELAY_W-1:0] tx_cnt;
  logic [DELAY_W-1:0] rx_cnt;
  logic [DELAY_W-1:0] stb_cnt;

  // Counter step
  // Counts edges while run is high, holds at lim, clears when run drops
  function automatic logic [DELAY_W-1:0] sat_step(input logic               run,
                                                  input logic [DELAY_W-1:0] cnt,
                                                  input logic [DELAY_W-1:0] lim);
    logic [DELAY_W-1:0] nxt;
    nxt = '0;
    if (run) begin
      nxt = (cnt < lim) ? cnt + 1'b1 : cnt;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Online delay counters
  // Level rises once input seen high for delay edges
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt        <= '0;
      rx_cnt        <= '0;
      tx_online_dly <= 1'b0;
      rx_online_dly <= 1'b0;
    end else begin
      tx_cnt        <= sat_step(tx_online, tx_cnt, delay_x_value);
      rx_cnt        <= sat_step(rx_online, rx_cnt, delay_y_value);
      // Drop at once on a low sample
      tx_online_dly <= tx_online && (tx_cnt >= delay_x_value);
      rx_online_dly <= rx_online && (rx_cnt >= delay_y_value);
    end
  end

  //////////////////////////////////////////////////
  // Strobe holdoff
  // Counts edges since tx_online_dly rose
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= sat_step(tx_online_dly, stb_cnt, delay_z_value);
    end
  end

  // Strobe passes delay_z edges after tx online
  assign auto_stb_userbit = tx_online_dly && (stb_cnt >= delay_z_value) && tx_stb_userbit;

  // Markers follow tx online directly
  assign auto_mrk_userbit = tx_online_dly ? tx_mrk_userbit : '0;

endmodule

/* source/st_beat_pack.sv */
// Stream beat packer that folds keep, data and last into one link word
module st_beat_pack
  import link_cfg_pkg::*;
(
  // User beat fields
  input  logic [KEEP_W-1:0] user_tkeep,
  input  logic [DATA_W-1:0] user_tdata,
  input  logic              user_tlast,

  // Packed word toward credit logic
  output st_word_t          st_word
);

  //////////////////////////////////////////////////
  // Field placement
  // Purely combinational, no state
  always_comb begin
    st_word = '0;

    // Byte enables in the top bits
    st_word[KEEP_LSB +: KEEP_W] = user_tkeep;

    // Payload
    st_word[DATA_LSB +: DATA_W] = user_tdata;

    // End of packet flag
    st_word[LAST_BIT]           = user_tlast;
  end

endmodule

/* source/phy_lane_pkg.sv */
// PHY lane layout for the transmit and receive lanes of the die-to-die link
package phy_lane_pkg;

  // Width of a single PHY lane
  localparam int LANE_W   = 40;

  //////////////////////////////////////////////////
  // Lane 0 layout
  localparam int PUSH_BIT = 0;
  // Low word slice, word bits 0 to 36
  localparam int LO_BITS  = 37;
  localparam int LO_LSB   = 1;
  localparam int STB_BIT  = 38;

  //////////////////////////////////////////////////
  // Lane 1 layout
  // High word slice, word bits 37 to 72
  localparam int HI_BITS  = 36;
  localparam int HI_LSB   = 0;
  // Bits 36 to 38 of lane 1 stay zero

  // Marker user bit, top bit of each lane
  localparam int MRK_BIT  = 39;

  //////////////////////////////////////////////////
  // Receive side
  // Credit pulse returned by the far end
  localparam int CRED_BIT = 0;

  typedef logic [LANE_W-1:0] lane_t;

endpackage

/* source/link_cfg_pkg.sv */
// Link configuration constants for the stream word and its sideband widths
package link_cfg_pkg;

  //////////////////////////////////////////////////
  // User stream widths
  localparam int DATA_W  = 64;
  localparam int KEEP_W  = 8;

  // One keep bit per data byte
  localparam int WORD_W  = KEEP_W + DATA_W + 1;

  //////////////////////////////////////////////////
  // Sequencer and status widths
  localparam int DELAY_W = 16;
  localparam int DEBUG_W = 32;

  //////////////////////////////////////////////////
  // Link word field positions
  // Keep on top, data in the middle, last at bit 0
  localparam int LAST_BIT = 0;
  localparam int DATA_LSB = LAST_BIT + 1;
  localparam int KEEP_LSB = DATA_LSB + DATA_W;

  // Packed link word, 73 bits
  typedef logic [WORD_W-1:0] st_word_t;

endpackage
